//--- source/bus_pkg.sv
// ##########################################################
// bus widths, slave address map and Wishbone field types
// shared by the fabric RTL and its testbench
// ##########################################################
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;    // byte address on every bus port
    typedef logic [31:0] data_t;    // read and write data

    localparam int N_SLAVES = 4;

    typedef logic [N_SLAVES-1:0] slave_sel_t;    // one-hot strobe, one bit per slave

    // address bits 15:12 pick the slave, anything above slave 3 is unmapped
    localparam int SLAVE_FIELD_LSB = 12;
    localparam int SLAVE_FIELD_MSB = 15;

    typedef logic [SLAVE_FIELD_MSB-SLAVE_FIELD_LSB:0] slave_field_t;

endpackage

`default_nettype wire

//--- source/auction_pkg.sv
// ##########################################################
// bid, balance and master types plus auction constants
// ##########################################################
`default_nettype none

package auction_pkg;

    localparam int N_MASTERS = 4;

    typedef logic [N_MASTERS-1:0] master_vec_t;    // one-hot grant or per-master flags
    typedef logic [3:0]           bid_t;           // zero means no bid
    typedef logic [9:0]           balance_t;       // spending balance, up to 1023

    // ##########################################################
    // budget rules
    // ##########################################################
    localparam balance_t BALANCE_INIT  = 10'd750;
    localparam balance_t REFILL_AMOUNT = 10'd750;
    localparam balance_t BALANCE_CAP   = 10'd900;    // a refill never goes past this

    typedef logic [8:0] refill_count_t;

    localparam refill_count_t REFILL_PERIOD = 9'd400;    // cycles between refills

    // ##########################################################
    // starvation guard
    // ##########################################################
    typedef logic [5:0] starve_count_t;

    // a requester that has waited this long goes ahead of every bid
    localparam starve_count_t STARVE_LIMIT = 6'd60;

    typedef enum logic {
        ARB_IDLE,     // bus free, auction runs every cycle
        ARB_OWNED     // one master holds the bus until it drops cyc
    } arb_state_t;

endpackage

`default_nettype wire

//--- source/wb_if.sv
// ##########################################################
// shared Wishbone-classic bus between master mux and decoder
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    import bus_pkg::*;

    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat_w;
    data_t dat_r;
    logic  ack;

    // the mux side drives the owner's request onto the bus
    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

    // the decoder side answers it
    modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

//--- source/auction_if.sv
// ##########################################################
// request, bid, affordability and grant signals between
// the auction arbiter and the budget bank
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

interface auction_if;
    import auction_pkg::*;

    master_vec_t req;                  // cyc high with a non-zero bid
    bid_t        bid [N_MASTERS];
    master_vec_t affordable;           // requester whose balance covers its bid
    master_vec_t grant;                // one-hot owner
    logic        charge;               // pulses on the first cycle of a new grant

    modport arbiter (output req, bid, grant, charge, input affordable);

    modport budget (input req, bid, grant, charge, output affordable);

endinterface

`default_nettype wire

//--- source/budget_bank.sv
// ##########################################################
// per-master spending balances with a periodic refill,
// charged once per tenure by the arbiter
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module budget_bank (
    input  logic      clk,
    input  logic      rst,
    auction_if.budget arb
);
    import auction_pkg::*;

    balance_t      balance [N_MASTERS];
    refill_count_t refill_timer;
    logic          refill;

    // subtract the winning bid, a balance never wraps below zero
    function automatic balance_t after_charge(balance_t bal, bid_t bid);
        if (bal >= balance_t'(bid)) begin
            return bal - balance_t'(bid);
        end
        return '0;
    endfunction

    // add one refill, clipped at the cap
    function automatic balance_t after_refill(balance_t bal);
        if (bal > BALANCE_CAP - REFILL_AMOUNT) begin
            return BALANCE_CAP;
        end
        return bal + REFILL_AMOUNT;
    endfunction

    assign refill = (refill_timer == REFILL_PERIOD - 1'b1);    // every 400th edge after reset

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refill_timer <= '0;
            for (int i = 0; i < N_MASTERS; i++) begin
                balance[i] <= BALANCE_INIT;
            end
        end else begin
            refill_timer <= refill ? '0 : refill_timer + 1'b1;
            for (int i = 0; i < N_MASTERS; i++) begin
                // a charge and a refill on the same edge both apply, charge first
                if (arb.charge && arb.grant[i] && refill) begin
                    balance[i] <= after_refill(after_charge(balance[i], arb.bid[i]));
                end else if (arb.charge && arb.grant[i]) begin
                    balance[i] <= after_charge(balance[i], arb.bid[i]);
                end else if (refill) begin
                    balance[i] <= after_refill(balance[i]);
                end
            end
        end
    end

    // only masters that are asking for the bus are flagged
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            arb.affordable[i] = arb.req[i] && (balance[i] >= balance_t'(arb.bid[i]));
        end
    end

endmodule

`default_nettype wire

//--- source/auction_arbiter.sv
// ##########################################################
// bus auction: starved masters first, then the highest
// affordable bid with round-robin ties, one tenure at a time
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module auction_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  auction_pkg::master_vec_t m_cyc,
    input  auction_pkg::bid_t        m_bid [auction_pkg::N_MASTERS],
    auction_if.arbiter               arb,
    output auction_pkg::master_vec_t grant
);
    import auction_pkg::*;

    arb_state_t    state;
    master_vec_t   req;
    master_vec_t   starved;
    master_vec_t   win;           // auction result for this cycle
    master_vec_t   award;         // win, but only when the bus is free
    master_vec_t   last_grant;    // owner of the previous tenure, seeds round-robin
    logic          charge;
    starve_count_t wait_count [N_MASTERS];

    // ##########################################################
    // request and starvation flags
    // ##########################################################
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            req[i]     = m_cyc[i] && (m_bid[i] != '0);
            starved[i] = req[i] && (wait_count[i] >= STARVE_LIMIT);
        end
    end

    // ##########################################################
    // winner selection
    // ##########################################################
    always_comb begin
        bid_t top_bid;
        int   base;
        int   idx;
        logic found;

        top_bid = '0;
        base    = 0;
        found   = 1'b0;
        win     = '0;

        for (int i = 0; i < N_MASTERS; i++) begin
            if (last_grant[i]) base = i;
        end

        for (int i = 0; i < N_MASTERS; i++) begin
            if (arb.affordable[i] && (m_bid[i] > top_bid)) top_bid = m_bid[i];
        end

        // walk round from the master after the last owner, first top bidder wins
        for (int k = 1; k <= N_MASTERS; k++) begin
            idx = (base + k) % N_MASTERS;
            if (!found && arb.affordable[idx] && (m_bid[idx] == top_bid)) begin
                win[idx] = 1'b1;
                found    = 1'b1;
            end
        end

        // a starved master overrides the auction, lowest number first
        if (|starved) begin
            win = '0;
            for (int i = N_MASTERS - 1; i >= 0; i--) begin
                if (starved[i]) win = master_vec_t'(1) << i;
            end
        end
    end

    assign award = (state == ARB_IDLE) ? win : '0;

    // ##########################################################
    // tenure FSM
    // ##########################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            charge     <= 1'b0;
            last_grant <= master_vec_t'(1) << (N_MASTERS - 1);    // master 0 is first in line
        end else begin
            charge <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (|award) begin
                        grant      <= award;
                        last_grant <= award;
                        charge     <= 1'b1;
                        state      <= ARB_OWNED;
                    end
                end
                ARB_OWNED: begin
                    if (!(|(grant & m_cyc))) begin    // owner dropped cyc, release the bus
                        grant <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // waiting requesters count up, owners and idle masters sit at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N_MASTERS; i++) begin
                wait_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_MASTERS; i++) begin
                if (!req[i] || grant[i] || award[i]) begin
                    wait_count[i] <= '0;
                end else if (wait_count[i] < STARVE_LIMIT) begin
                    wait_count[i] <= wait_count[i] + 1'b1;
                end
            end
        end
    end

    assign arb.req    = req;
    assign arb.bid    = m_bid;
    assign arb.grant  = grant;
    assign arb.charge = charge;

endmodule

`default_nettype wire

//--- source/master_mux.sv
// ##########################################################
// puts the bus owner on the shared bus and hands the
// response back to it alone
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module master_mux (
    input  auction_pkg::master_vec_t grant,
    input  auction_pkg::master_vec_t m_cyc,
    input  auction_pkg::master_vec_t m_stb,
    input  auction_pkg::master_vec_t m_we,
    input  bus_pkg::addr_t           m_adr   [auction_pkg::N_MASTERS],
    input  bus_pkg::data_t           m_dat_w [auction_pkg::N_MASTERS],
    output bus_pkg::data_t           m_dat_r [auction_pkg::N_MASTERS],
    output auction_pkg::master_vec_t m_ack,
    wb_if.master                     bus
);
    import auction_pkg::*;

    // with no owner the bus sits idle with cyc and stb low
    always_comb begin
        bus.cyc   = 1'b0;
        bus.stb   = 1'b0;
        bus.we    = 1'b0;
        bus.adr   = '0;
        bus.dat_w = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) begin
                bus.cyc   = m_cyc[i];
                bus.stb   = m_stb[i];
                bus.we    = m_we[i];
                bus.adr   = m_adr[i];
                bus.dat_w = m_dat_w[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            m_ack[i]   = grant[i] & bus.ack;               // losers never see an ack
            m_dat_r[i] = grant[i] ? bus.dat_r : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/slave_decoder.sv
// ##########################################################
// address decode to one slave strobe, response mux, and a
// zero-data ack for unmapped addresses
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module slave_decoder (
    input  logic               clk,
    input  logic               rst,
    wb_if.slave                bus,
    output logic               s_cyc,
    output logic               s_we,
    output bus_pkg::addr_t     s_adr,
    output bus_pkg::data_t     s_dat_w,
    output bus_pkg::slave_sel_t s_stb,
    input  bus_pkg::data_t     s_dat_r [bus_pkg::N_SLAVES],
    input  bus_pkg::slave_sel_t s_ack
);
    import bus_pkg::*;

    slave_field_t field;
    logic         mapped;
    logic         unmapped_stb;
    logic         unmapped_ack;    // registered answer for a missing slave

    assign field        = bus.adr[SLAVE_FIELD_MSB:SLAVE_FIELD_LSB];
    assign mapped       = (field < N_SLAVES);
    assign unmapped_stb = bus.cyc && bus.stb && !mapped;

    assign s_cyc   = bus.cyc;
    assign s_we    = bus.we;
    assign s_adr   = bus.adr;
    assign s_dat_w = bus.dat_w;

    always_comb begin
        s_stb     = '0;
        bus.dat_r = '0;    // unmapped reads return zero
        bus.ack   = unmapped_ack;
        for (int s = 0; s < N_SLAVES; s++) begin
            if (mapped && (field == slave_field_t'(s))) begin
                s_stb[s]  = bus.cyc & bus.stb;
                bus.dat_r = s_dat_r[s];
                bus.ack   = s_ack[s];
            end
        end
    end

    // ack one cycle after the strobe, toggling so that back-to-back accesses each get one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            unmapped_ack <= 1'b0;
        end else if (!unmapped_stb) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= !unmapped_ack;
        end
    end

endmodule

`default_nettype wire

//--- source/bus_fabric_top.sv
// ##########################################################
// four-master, four-slave Wishbone fabric with a bid-based
// arbiter, plain ports on both sides
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_top (
    input  logic                     clk,
    input  logic                     rst,

    // master side
    input  auction_pkg::master_vec_t m_cyc,
    input  auction_pkg::master_vec_t m_stb,
    input  auction_pkg::master_vec_t m_we,
    input  bus_pkg::addr_t           m_adr   [auction_pkg::N_MASTERS],
    input  bus_pkg::data_t           m_dat_w [auction_pkg::N_MASTERS],
    input  auction_pkg::bid_t        m_bid   [auction_pkg::N_MASTERS],
    output bus_pkg::data_t           m_dat_r [auction_pkg::N_MASTERS],
    output auction_pkg::master_vec_t m_ack,

    // slave side
    output logic                     s_cyc,
    output logic                     s_we,
    output bus_pkg::addr_t           s_adr,
    output bus_pkg::data_t           s_dat_w,
    output bus_pkg::slave_sel_t      s_stb,
    input  bus_pkg::data_t           s_dat_r [bus_pkg::N_SLAVES],
    input  bus_pkg::slave_sel_t      s_ack
);
    import auction_pkg::*;

    master_vec_t grant;    // one-hot bus owner

    wb_if      wb ();
    auction_if arb_bus ();

    auction_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .m_cyc (m_cyc),
        .m_bid (m_bid),
        .arb   (arb_bus.arbiter),
        .grant (grant)
    );

    budget_bank u_budget (
        .clk (clk),
        .rst (rst),
        .arb (arb_bus.budget)
    );

    master_mux u_mux (
        .grant   (grant),
        .m_cyc   (m_cyc),
        .m_stb   (m_stb),
        .m_we    (m_we),
        .m_adr   (m_adr),
        .m_dat_w (m_dat_w),
        .m_dat_r (m_dat_r),
        .m_ack   (m_ack),
        .bus     (wb.master)
    );

    slave_decoder u_decoder (
        .clk     (clk),
        .rst     (rst),
        .bus     (wb.slave),
        .s_cyc   (s_cyc),
        .s_we    (s_we),
        .s_adr   (s_adr),
        .s_dat_w (s_dat_w),
        .s_stb   (s_stb),
        .s_dat_r (s_dat_r),
        .s_ack   (s_ack)
    );

endmodule

`default_nettype wire

//--- test/fabric_checker.sv
// ##########################################################
// watches the fabric ports, models balances and ownership,
// and reports each stimulus row as it finishes
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module fabric_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  auction_pkg::master_vec_t m_cyc,
    input  auction_pkg::master_vec_t m_we,
    input  auction_pkg::bid_t        m_bid   [auction_pkg::N_MASTERS],
    input  bus_pkg::data_t           m_dat_r [auction_pkg::N_MASTERS],
    input  auction_pkg::master_vec_t m_ack,
    input  logic                     s_cyc,
    input  bus_pkg::slave_sel_t      s_stb,
    input  bus_pkg::addr_t           s_adr
);
    import auction_pkg::*;
    import bus_pkg::*;

    int       errors     = 0;
    int       tests      = 0;
    int       failed     = 0;
    int       row_errors = 0;
    int       cycle      = 0;
    int       last_owner = N_MASTERS - 1;    // round-robin starts at master 0
    int       exp_owner;
    int       first_owner;
    int       watch      = -1;               // master whose wait is being timed
    int       waited;
    data_t    exp_data;
    data_t    first_data;
    logic     first_we;
    string    row_name   = "reset";
    balance_t bal [N_MASTERS];

    task automatic flag(input string msg);
        $display("%s", msg);
        errors++;
        row_errors++;
    endtask

    // a negative expected owner means the balance model picks the winner
    task automatic start_row(input string name, input master_vec_t req, input logic [15:0] bids,
                             input int exp, input data_t edata, input int w);
        int top;
        int idx;
        row_name    = name;
        exp_data    = edata;
        exp_owner   = exp;
        watch       = w;
        waited      = 0;
        first_owner = -1;
        row_errors  = 0;
        if (exp < 0) begin
            top = 0;
            for (int k = 1; k <= N_MASTERS; k++) begin
                idx = (last_owner + k) % N_MASTERS;    // first in round-robin order keeps a tie
                if (req[idx] && bids[idx*4 +: 4] > top && bal[idx] >= bids[idx*4 +: 4]) begin
                    top       = bids[idx*4 +: 4];
                    exp_owner = idx;
                end
            end
        end
    endtask

    task automatic end_row();
        tests++;
        if (first_owner != exp_owner) begin
            flag($sformatf("Mismatch %s: winner expected %0d actual %0d",
                           row_name, exp_owner, first_owner));
        end else if (!first_we && first_data !== exp_data) begin
            flag($sformatf("Mismatch %s: read data expected %h actual %h",
                           row_name, exp_data, first_data));
        end
        if (row_errors != 0) failed++;
        $display("%s %s", (row_errors == 0) ? "PASS" : "FAIL", row_name);
    endtask

    task automatic report();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    endtask

    // refill every REFILL_PERIOD cycles after reset release
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle = 0;
            for (int i = 0; i < N_MASTERS; i++) bal[i] = BALANCE_INIT;
        end else begin
            cycle++;
            if (cycle % REFILL_PERIOD == 0) begin
                for (int i = 0; i < N_MASTERS; i++) begin
                    if (int'(bal[i]) + int'(REFILL_AMOUNT) > int'(BALANCE_CAP)) begin
                        bal[i] = BALANCE_CAP;
                    end else begin
                        bal[i] = bal[i] + REFILL_AMOUNT;
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        slave_sel_t exp_stb;
        if (!rst) begin
            exp_stb = (s_adr[SLAVE_FIELD_MSB:SLAVE_FIELD_LSB] < N_SLAVES) ?
                      slave_sel_t'(1) << s_adr[SLAVE_FIELD_MSB:SLAVE_FIELD_LSB] : '0;
            if (s_stb != '0 && s_stb != exp_stb) begin
                flag($sformatf("Mismatch %s: s_stb expected %b actual %b",
                               row_name, exp_stb, s_stb));
            end
            // the shared cycle line is high under any strobe or ack and low with no master active
            if ((s_stb != '0 || m_ack != '0) && s_cyc !== 1'b1) begin
                flag($sformatf("Mismatch %s: s_cyc expected 1 actual %b", row_name, s_cyc));
            end
            if (m_cyc == '0 && s_cyc !== 1'b0) begin
                flag($sformatf("Mismatch %s: s_cyc expected 0 actual %b", row_name, s_cyc));
            end
            for (int m = 0; m < N_MASTERS; m++) begin
                if (m_ack[m]) begin
                    bal[m] = (bal[m] >= m_bid[m]) ? bal[m] - m_bid[m] : '0;    // one ack per tenure
                    last_owner = m;
                    if (first_owner < 0) begin
                        first_owner = m;
                        first_data  = m_dat_r[m];
                        first_we    = m_we[m];
                    end
                end
            end
            if (watch >= 0) begin
                if (m_ack[watch]) begin
                    watch = -1;
                end else if (m_cyc[watch]) begin
                    waited++;
                    if (waited == STARVE_LIMIT + 8) begin
                        flag($sformatf("master %0d in %s waited %0d cycles and was never served",
                                       watch, row_name, waited));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/fabric_tb.sv
// ##########################################################
// drives the fabric from a stimulus table, models the four
// slaves and stops the run with a watchdog
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;
    import auction_pkg::*;
    import bus_pkg::*;

    localparam int MAX_ROWS    = 80;
    localparam int SLAVE_WORDS = 64;

    logic        clk;
    logic        rst;
    master_vec_t m_cyc;
    master_vec_t m_stb;
    master_vec_t m_we;
    master_vec_t m_ack;
    addr_t       m_adr   [N_MASTERS];
    data_t       m_dat_w [N_MASTERS];
    data_t       m_dat_r [N_MASTERS];
    bid_t        m_bid   [N_MASTERS];
    logic        s_cyc;
    logic        s_we;
    addr_t       s_adr;
    data_t       s_dat_w;
    slave_sel_t  s_stb;
    slave_sel_t  s_ack;
    data_t       s_dat_r [N_SLAVES];
    data_t       mem     [N_SLAVES][SLAVE_WORDS];

    // stimulus table with the bids packed four bits per master
    string       row_name  [MAX_ROWS];
    master_vec_t row_cyc   [MAX_ROWS];
    master_vec_t row_we    [MAX_ROWS];
    addr_t       row_adr   [MAX_ROWS];
    data_t       row_dat   [MAX_ROWS];
    logic [15:0] row_bids  [MAX_ROWS];
    int          row_exp   [MAX_ROWS];    // -1 lets the checker's balance model decide
    data_t       row_rdat  [MAX_ROWS];
    int          row_reps  [MAX_ROWS];    // accesses per requesting master
    logic        row_first [MAX_ROWS];    // losers withdraw after the first ack
    int          row_watch [MAX_ROWS];    // master timed for starvation or -1 for none
    int          n_rows = 0;
    int          seed   = 32'h8763;
    data_t       wdat;

    bus_fabric_top dut (.*);

    fabric_checker u_checker (.clk(clk), .rst(rst), .m_cyc(m_cyc), .m_we(m_we), .m_bid(m_bid),
                              .m_dat_r(m_dat_r), .m_ack(m_ack), .s_cyc(s_cyc), .s_stb(s_stb),
                              .s_adr(s_adr));

    always #4 clk = ~clk;

    // ##########################################################
    // slave memories that ack one cycle after their strobe
    // ##########################################################
    for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave
        always @(posedge clk or posedge rst) begin
            if (rst) begin
                s_ack[s] <= 1'b0;
            end else begin
                s_ack[s] <= s_stb[s] && !s_ack[s];
                if (s_stb[s] && s_we && !s_ack[s]) mem[s][s_adr[7:2]] <= s_dat_w;
            end
        end
        assign s_dat_r[s] = mem[s][s_adr[7:2]];
    end

    task automatic add_row(input string name, input master_vec_t cyc, input master_vec_t we,
                           input addr_t adr, input data_t dat, input logic [15:0] bids,
                           input int exp, input data_t rdat, input int reps,
                           input logic first_only, input int watch);
        row_name[n_rows]  = name;
        row_cyc[n_rows]   = cyc;
        row_we[n_rows]    = we;
        row_adr[n_rows]   = adr;
        row_dat[n_rows]   = dat;
        row_bids[n_rows]  = bids;
        row_exp[n_rows]   = exp;
        row_rdat[n_rows]  = rdat;
        row_reps[n_rows]  = reps;
        row_first[n_rows] = first_only;
        row_watch[n_rows] = watch;
        n_rows++;
    endtask

    // one master's share of a row with each access held until its ack
    task automatic run_master(input int r, input int m);
        if (!row_cyc[r][m]) return;
        for (int n = 0; n < row_reps[r]; n++) begin
            m_cyc[m]   = 1'b1;
            m_stb[m]   = 1'b1;
            m_we[m]    = row_we[r][m];
            m_adr[m]   = row_adr[r] + addr_t'(m << 2);
            m_dat_w[m] = row_dat[r];
            m_bid[m]   = row_bids[r][m*4 +: 4];
            do @(negedge clk); while (!m_ack[m] && !(row_first[r] && m_ack != '0));
            @(posedge clk);
            #1;
            m_cyc[m] = 1'b0;
            m_stb[m] = 1'b0;
            m_bid[m] = '0;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        m_cyc = '0;
        m_stb = '0;
        m_we  = '0;
        s_ack = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            m_adr[m]   = '0;
            m_dat_w[m] = '0;
            m_bid[m]   = '0;
        end
        for (int s = 0; s < N_SLAVES; s++) begin
            for (int w = 0; w < SLAVE_WORDS; w++) mem[s][w] = 32'h5a5a_0000 ^ ((s << 12) | (w << 2));
        end
        for (int s = 0; s < N_SLAVES; s++) begin
            wdat = $random(seed);
            add_row($sformatf("write slave %0d", s), 4'b0001, 4'b0001, addr_t'((s << 12) | 32'h40),
                    wdat, 16'h0001, 0, '0, 1, 1'b0, -1);
            add_row($sformatf("read slave %0d", s), 4'b0001, 4'b0000, addr_t'((s << 12) | 32'h40),
                    '0, 16'h0001, 0, wdat, 1, 1'b0, -1);
        end
        add_row("unmapped read", 4'b0001, 4'b0000, 32'h7040, '0, 16'h0001, 0, '0, 1, 1'b0, -1);
        for (int i = 0; i < 52; i++) begin
            add_row($sformatf("budget %0d", i), 4'b1010, 4'b1010, 32'h2100, $random(seed),
                    16'hf020, -1, '0, 1, 1'b1, -1);
        end
        add_row("starvation", 4'b1111, 4'b1111, 32'h3000, $random(seed), 16'h5999, -1, '0, 8,
                1'b0, 3);
        add_row("highest bid", 4'b1111, 4'b1111, 32'h1000, $random(seed), 16'h2c73, 2, '0, 1,
                1'b1, -1);
        add_row("tie first", 4'b0011, 4'b0011, 32'h1080, $random(seed), 16'h0099, 0, '0, 1,
                1'b1, -1);
        add_row("tie repeat", 4'b0011, 4'b0011, 32'h1080, $random(seed), 16'h0099, 1, '0, 1,
                1'b1, -1);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            u_checker.start_row(row_name[r], row_cyc[r], row_bids[r], row_exp[r], row_rdat[r],
                                row_watch[r]);
            fork
                run_master(r, 0);
                run_master(r, 1);
                run_master(r, 2);
                run_master(r, 3);
            join
            u_checker.end_row();
        end
        u_checker.report();
        if (u_checker.errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        #1;
        repeat (n_rows * (int'(STARVE_LIMIT) + 20)) @(posedge clk);
        $display("timeout: the stimulus table did not finish in %0d rows' time", n_rows);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/bus_pkg.sv
source/auction_pkg.sv
source/wb_if.sv
source/auction_if.sv
source/budget_bank.sv
source/auction_arbiter.sv
source/master_mux.sv
source/slave_decoder.sv
source/bus_fabric_top.sv
test/fabric_checker.sv
test/fabric_tb.sv

//--- Bender.yml
package:
  name: bus_fabric

sources:
  - files:
      - source/bus_pkg.sv
      - source/auction_pkg.sv
      - source/wb_if.sv
      - source/auction_if.sv
      - source/budget_bank.sv
      - source/auction_arbiter.sv
      - source/master_mux.sv
      - source/slave_decoder.sv
      - source/bus_fabric_top.sv
  - target: test
    files:
      - test/fabric_checker.sv
      - test/fabric_tb.sv
